/* verilog/cpu_pkg.sv */
package cpu_pkg;

  // datapath and instruction width, every register and memory word is this wide
  localparam int word_w = 16;

  // eight architectural registers need a three bit index
  localparam int reg_w = 3;

  // opcode sits in the top five bits of every instruction
  localparam int op_w = 5;

  // jal always writes its return address here
  localparam logic [reg_w-1:0] link_reg = 3'd7;

  // on-chip memories, both addressed by word
  localparam int imem_depth = 256;
  localparam int dmem_depth = 256;
  localparam int imem_aw = $clog2(imem_depth);
  localparam int dmem_aw = $clog2(dmem_depth);

  // bit positions of the instruction fields
  localparam int op_lsb = 11;
  localparam int rs_lsb = 8;
  localparam int rt_lsb = 5;
  localparam int rd_lsb = 2;

  // immediate field widths, all sign extended from the low bits
  localparam int imm5_w = 5;
  localparam int imm8_w = 8;
  localparam int disp_w = 11;

  // opcodes of the supported subset
  localparam logic [op_w-1:0] op_halt = 5'b00000;
  localparam logic [op_w-1:0] op_j    = 5'b00100;
  localparam logic [op_w-1:0] op_jr   = 5'b00101;
  localparam logic [op_w-1:0] op_jal  = 5'b00110;
  localparam logic [op_w-1:0] op_addi = 5'b01000;
  localparam logic [op_w-1:0] op_beqz = 5'b01100;
  localparam logic [op_w-1:0] op_st   = 5'b10000;
  localparam logic [op_w-1:0] op_ld   = 5'b10001;
  localparam logic [op_w-1:0] op_stu  = 5'b10011;
  localparam logic [op_w-1:0] op_lbi  = 5'b11000;
  localparam logic [op_w-1:0] op_add  = 5'b11011;

  // next pc selection driven by decode
  localparam int pc_src_w = 2;
  localparam logic [pc_src_w-1:0] pc_seq      = 2'b00;
  localparam logic [pc_src_w-1:0] pc_redirect = 2'b10;

  // hex image loaded into the instruction rom
  localparam string rom_file = "program.hex";

endpackage

/* verilog/hazard_det.sv */
`timescale 1ns/1ps

module hazard_det (
  input  logic [cpu_pkg::reg_w-1:0]    dec_rs,
  input  logic [cpu_pkg::reg_w-1:0]    dec_rt,
  input  logic [cpu_pkg::reg_w-1:0]    id_ex_rd,
  input  logic                         id_ex_reg_write,
  input  logic [cpu_pkg::reg_w-1:0]    ex_mem_rd,
  input  logic [cpu_pkg::reg_w-1:0]    ex_mem_rs,
  input  logic                         ex_mem_reg_write,
  input  logic [cpu_pkg::word_w-1:0]   id_ex_ins,
  input  logic [cpu_pkg::word_w-1:0]   ex_mem_ins,
  input  logic [cpu_pkg::pc_src_w-1:0] pc_source,
  output logic                         stall_decode,
  output logic                         flush_fetch
);

  import cpu_pkg::*;

  logic [op_w-1:0]  id_ex_op;
  logic [op_w-1:0]  ex_mem_op;
  logic [reg_w-1:0] id_ex_base;
  logic             ex_hit;
  logic             mem_hit;
  logic             stu_hit;

  assign id_ex_op   = id_ex_ins[op_lsb +: op_w];
  assign ex_mem_op  = ex_mem_ins[op_lsb +: op_w];
  assign id_ex_base = id_ex_ins[rs_lsb +: reg_w];

  // producer in execute or memory writes a register that decode wants to read
  assign ex_hit  = id_ex_reg_write && ((id_ex_rd == dec_rs) || (id_ex_rd == dec_rt));
  assign mem_hit = ex_mem_reg_write && ((ex_mem_rd == dec_rs) || (ex_mem_rd == dec_rt));

  // stu writes its base register back, so it is tracked by opcode and rs
  assign stu_hit = ((id_ex_op == op_stu) && ((id_ex_base == dec_rs) || (id_ex_base == dec_rt)))
                || ((ex_mem_op == op_stu) && ((ex_mem_rs == dec_rs) || (ex_mem_rs == dec_rt)));

  // without forwarding the only cure is to hold decode until writeback
  assign stall_decode = ex_hit || mem_hit || stu_hit;

  // a taken control transfer kills the instruction behind it in fetch
  assign flush_fetch = (pc_source == pc_redirect);

endmodule

/* verilog/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       stall_decode,
  input  logic                       flush_fetch,
  input  logic                       halt_seen,
  input  logic [cpu_pkg::word_w-1:0] target,
  output logic [cpu_pkg::word_w-1:0] if_ins,
  output logic [cpu_pkg::word_w-1:0] if_pc,
  output logic                       if_valid
);

  import cpu_pkg::*;

  logic [word_w-1:0] rom [imem_depth];
  logic [word_w-1:0] pc;

  initial begin
    $readmemh(rom_file, rom);
  end

  // the pc counts words, so sequential flow adds one
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc       <= '0;
      if_ins   <= '0;
      if_pc    <= '0;
      if_valid <= 1'b0;
    end else if (flush_fetch) begin
      // on a redirect from decode the word just read is on the wrong path
      pc       <= target;
      if_ins   <= '0;
      if_valid <= 1'b0;
    end else if (stall_decode) begin
      // decode is waiting on a producer so both pc and IF/ID hold
      pc <= pc;
    end else if (halt_seen) begin
      // pc stays frozen and decode only sees bubbles from here on
      if_ins   <= '0;
      if_valid <= 1'b0;
    end else begin
      pc       <= pc + word_w'(1);
      if_ins   <= rom[pc[imem_aw-1:0]];
      if_pc    <= pc;
      if_valid <= 1'b1;
    end
  end

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic [cpu_pkg::word_w-1:0]   if_ins,
  input  logic [cpu_pkg::word_w-1:0]   if_pc,
  input  logic                         if_valid,
  input  logic                         stall_decode,
  input  logic                         wb_en,
  input  logic [cpu_pkg::reg_w-1:0]    wb_reg,
  input  logic [cpu_pkg::word_w-1:0]   wb_data,
  output logic [cpu_pkg::reg_w-1:0]    dec_rs,
  output logic [cpu_pkg::reg_w-1:0]    dec_rt,
  output logic [cpu_pkg::pc_src_w-1:0] pc_source,
  output logic [cpu_pkg::word_w-1:0]   target,
  output logic                         halt_seen,
  output logic                         id_ex_valid,
  output logic [cpu_pkg::word_w-1:0]   id_ex_ins,
  output logic [cpu_pkg::word_w-1:0]   id_ex_pc,
  output logic [cpu_pkg::reg_w-1:0]    id_ex_rd,
  output logic                         id_ex_reg_write,
  output logic [cpu_pkg::word_w-1:0]   id_ex_a,
  output logic [cpu_pkg::word_w-1:0]   id_ex_b,
  output logic [cpu_pkg::word_w-1:0]   id_ex_imm
);

  import cpu_pkg::*;

  logic [word_w-1:0] regs [2**reg_w];
  logic [op_w-1:0]   op;
  logic [word_w-1:0] rd_a;
  logic [word_w-1:0] rd_b;
  logic [word_w-1:0] imm5_ext;
  logic [word_w-1:0] imm8_ext;
  logic [word_w-1:0] disp_ext;
  logic [word_w-1:0] imm_sel;
  logic [word_w-1:0] next_pc;
  logic [reg_w-1:0]  dest;
  logic              writes;
  logic              take;
  logic              issue;
  logic              halt_q;

  // rs is always bits 10 to 8, and rt doubles as the store data source of st and stu
  assign op     = if_ins[op_lsb +: op_w];
  assign dec_rs = if_ins[rs_lsb +: reg_w];
  assign dec_rt = if_ins[rt_lsb +: reg_w];

  // writeback lands in the same cycle that decode reads, so bypass it around the array
  assign rd_a = (wb_en && (wb_reg == dec_rs)) ? wb_data : regs[dec_rs];
  assign rd_b = (wb_en && (wb_reg == dec_rt)) ? wb_data : regs[dec_rt];

  assign imm5_ext = {{(word_w-imm5_w){if_ins[imm5_w-1]}}, if_ins[imm5_w-1:0]};
  assign imm8_ext = {{(word_w-imm8_w){if_ins[imm8_w-1]}}, if_ins[imm8_w-1:0]};
  assign disp_ext = {{(word_w-disp_w){if_ins[disp_w-1]}}, if_ins[disp_w-1:0]};
  assign next_pc  = if_pc + word_w'(1);

  // only a real instruction with its operands settled may move on
  assign issue = if_valid && !stall_decode;

  always_comb begin
    dest    = if_ins[rt_lsb +: reg_w];
    writes  = 1'b0;
    imm_sel = imm5_ext;
    take    = 1'b0;
    target  = next_pc;
    case (op)
      op_add: begin
        dest   = if_ins[rd_lsb +: reg_w];
        writes = 1'b1;
      end
      op_addi, op_ld: writes = 1'b1;
      op_lbi: begin
        dest    = dec_rs;
        writes  = 1'b1;
        imm_sel = imm8_ext;
      end
      op_beqz: begin
        imm_sel = imm8_ext;
        take    = (rd_a == '0);
        target  = next_pc + imm8_ext;
      end
      op_j: begin
        imm_sel = disp_ext;
        take    = 1'b1;
        target  = next_pc + disp_ext;
      end
      op_jal: begin
        dest    = link_reg;
        writes  = 1'b1;
        imm_sel = disp_ext;
        take    = 1'b1;
        target  = next_pc + disp_ext;
      end
      op_jr: begin
        imm_sel = imm8_ext;
        take    = 1'b1;
        target  = rd_a + imm8_ext;
      end
      // st and stu keep imm5 and write nothing here since stu's rs update is tracked by opcode
      default: writes = 1'b0;
    endcase
  end

  assign pc_source = (issue && take) ? pc_redirect : pc_seq;

  // halt freezes fetch the cycle it issues and for the rest of the run
  assign halt_seen = halt_q || (issue && (op == op_halt));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halt_q <= 1'b0;
    end else if (issue && (op == op_halt)) begin
      halt_q <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**reg_w; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en) begin
      regs[wb_reg] <= wb_data;
    end
  end

  // in the control half of ID/EX a stall sends a bubble down to execute
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex_valid     <= 1'b0;
      id_ex_ins       <= '0;
      id_ex_reg_write <= 1'b0;
    end else if (!issue) begin
      id_ex_valid     <= 1'b0;
      id_ex_ins       <= '0;
      id_ex_reg_write <= 1'b0;
    end else begin
      id_ex_valid     <= 1'b1;
      id_ex_ins       <= if_ins;
      id_ex_reg_write <= writes;
    end
  end

  always_ff @(posedge clk) begin
    id_ex_pc  <= if_pc;
    id_ex_rd  <= dest;
    id_ex_a   <= rd_a;
    id_ex_b   <= rd_b;
    id_ex_imm <= imm_sel;
  end

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       id_ex_valid,
  input  logic [cpu_pkg::word_w-1:0] id_ex_ins,
  input  logic [cpu_pkg::word_w-1:0] id_ex_pc,
  input  logic [cpu_pkg::reg_w-1:0]  id_ex_rd,
  input  logic                       id_ex_reg_write,
  input  logic [cpu_pkg::word_w-1:0] id_ex_a,
  input  logic [cpu_pkg::word_w-1:0] id_ex_b,
  input  logic [cpu_pkg::word_w-1:0] id_ex_imm,
  output logic                       ex_mem_valid,
  output logic [cpu_pkg::word_w-1:0] ex_mem_ins,
  output logic [cpu_pkg::reg_w-1:0]  ex_mem_rd,
  output logic [cpu_pkg::reg_w-1:0]  ex_mem_rs,
  output logic                       ex_mem_reg_write,
  output logic [cpu_pkg::word_w-1:0] ex_mem_result,
  output logic [cpu_pkg::word_w-1:0] ex_mem_addr,
  output logic [cpu_pkg::word_w-1:0] ex_mem_store_data
);

  import cpu_pkg::*;

  logic [op_w-1:0]   op;
  logic [word_w-1:0] addr;
  logic [word_w-1:0] result;

  assign op = id_ex_ins[op_lsb +: op_w];

  // ld, st and stu all address memory at base plus offset
  assign addr = id_ex_a + id_ex_imm;

  always_comb begin
    case (op)
      op_add:  result = id_ex_a + id_ex_b;
      op_addi: result = id_ex_a + id_ex_imm;
      op_lbi:  result = id_ex_imm;
      // link address is the word after the jal
      op_jal:  result = id_ex_pc + word_w'(1);
      default: result = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_mem_valid     <= 1'b0;
      ex_mem_ins       <= '0;
      ex_mem_reg_write <= 1'b0;
    end else begin
      ex_mem_valid     <= id_ex_valid;
      ex_mem_ins       <= id_ex_ins;
      ex_mem_reg_write <= id_ex_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    ex_mem_rd         <= id_ex_rd;
    ex_mem_rs         <= id_ex_ins[rs_lsb +: reg_w];
    ex_mem_result     <= result;
    ex_mem_addr       <= addr;
    ex_mem_store_data <= id_ex_b;
  end

endmodule

/* verilog/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       ex_mem_valid,
  input  logic [cpu_pkg::word_w-1:0] ex_mem_ins,
  input  logic [cpu_pkg::reg_w-1:0]  ex_mem_rd,
  input  logic [cpu_pkg::reg_w-1:0]  ex_mem_rs,
  input  logic                       ex_mem_reg_write,
  input  logic [cpu_pkg::word_w-1:0] ex_mem_result,
  input  logic [cpu_pkg::word_w-1:0] ex_mem_addr,
  input  logic [cpu_pkg::word_w-1:0] ex_mem_store_data,
  output logic                       wb_en,
  output logic [cpu_pkg::reg_w-1:0]  wb_reg,
  output logic [cpu_pkg::word_w-1:0] wb_data,
  output logic                       retire_valid,
  output logic [cpu_pkg::reg_w-1:0]  retire_reg,
  output logic [cpu_pkg::word_w-1:0] retire_data,
  output logic                       halted
);

  import cpu_pkg::*;

  logic [word_w-1:0] ram [dmem_depth];
  logic [op_w-1:0]   op;
  logic [word_w-1:0] load_data;
  logic              is_stu;
  logic              mem_wb_halt;

  assign op     = ex_mem_ins[op_lsb +: op_w];
  assign is_stu = (op == op_stu);

  // asynchronous read so the load value is ready for MEM/WB in the same cycle
  assign load_data = ram[ex_mem_addr[dmem_aw-1:0]];

  always_ff @(posedge clk) begin
    if (ex_mem_valid && ((op == op_st) || is_stu)) begin
      ram[ex_mem_addr[dmem_aw-1:0]] <= ex_mem_store_data;
    end
  end

  // MEM/WB control, stu writes back even though decode gave it no rd
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_en       <= 1'b0;
      mem_wb_halt <= 1'b0;
      halted      <= 1'b0;
    end else begin
      wb_en       <= ex_mem_valid && (ex_mem_reg_write || is_stu);
      mem_wb_halt <= ex_mem_valid && (op == op_halt);
      // sticky, raised once the halt has passed through writeback
      halted      <= halted || mem_wb_halt;
    end
  end

  always_ff @(posedge clk) begin
    wb_reg <= is_stu ? ex_mem_rs : ex_mem_rd;
    if (op == op_ld) begin
      wb_data <= load_data;
    end else if (is_stu) begin
      wb_data <= ex_mem_addr;
    end else begin
      wb_data <= ex_mem_result;
    end
  end

  // each register write is one retirement
  assign retire_valid = wb_en;
  assign retire_reg   = wb_reg;
  assign retire_data  = wb_data;

endmodule

/* verilog/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
  input  logic                       clk,
  input  logic                       arst_n,
  output logic                       retire_valid,
  output logic [cpu_pkg::reg_w-1:0]  retire_reg,
  output logic [cpu_pkg::word_w-1:0] retire_data,
  output logic                       halted
);

  import cpu_pkg::*;

  // fetch to decode
  logic [word_w-1:0]   if_ins;
  logic [word_w-1:0]   if_pc;
  logic                if_valid;

  // control between decode, fetch and the interlock
  logic                stall_decode;
  logic                flush_fetch;
  logic                halt_seen;
  logic [word_w-1:0]   target;
  logic [pc_src_w-1:0] pc_source;
  logic [reg_w-1:0]    dec_rs;
  logic [reg_w-1:0]    dec_rt;

  // decode to execute
  logic                id_ex_valid;
  logic [word_w-1:0]   id_ex_ins;
  logic [word_w-1:0]   id_ex_pc;
  logic [reg_w-1:0]    id_ex_rd;
  logic                id_ex_reg_write;
  logic [word_w-1:0]   id_ex_a;
  logic [word_w-1:0]   id_ex_b;
  logic [word_w-1:0]   id_ex_imm;

  // execute to memory
  logic                ex_mem_valid;
  logic [word_w-1:0]   ex_mem_ins;
  logic [reg_w-1:0]    ex_mem_rd;
  logic [reg_w-1:0]    ex_mem_rs;
  logic                ex_mem_reg_write;
  logic [word_w-1:0]   ex_mem_result;
  logic [word_w-1:0]   ex_mem_addr;
  logic [word_w-1:0]   ex_mem_store_data;

  // writeback into the register file
  logic                wb_en;
  logic [reg_w-1:0]    wb_reg;
  logic [word_w-1:0]   wb_data;

  fetch_stage fetch_stage_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .stall_decode (stall_decode),
    .flush_fetch  (flush_fetch),
    .halt_seen    (halt_seen),
    .target       (target),
    .if_ins       (if_ins),
    .if_pc        (if_pc),
    .if_valid     (if_valid)
  );

  decode_stage decode_stage_inst (
    .clk             (clk),
    .arst_n          (arst_n),
    .if_ins          (if_ins),
    .if_pc           (if_pc),
    .if_valid        (if_valid),
    .stall_decode    (stall_decode),
    .wb_en           (wb_en),
    .wb_reg          (wb_reg),
    .wb_data         (wb_data),
    .dec_rs          (dec_rs),
    .dec_rt          (dec_rt),
    .pc_source       (pc_source),
    .target          (target),
    .halt_seen       (halt_seen),
    .id_ex_valid     (id_ex_valid),
    .id_ex_ins       (id_ex_ins),
    .id_ex_pc        (id_ex_pc),
    .id_ex_rd        (id_ex_rd),
    .id_ex_reg_write (id_ex_reg_write),
    .id_ex_a         (id_ex_a),
    .id_ex_b         (id_ex_b),
    .id_ex_imm       (id_ex_imm)
  );

  execute_stage execute_stage_inst (
    .clk               (clk),
    .arst_n            (arst_n),
    .id_ex_valid       (id_ex_valid),
    .id_ex_ins         (id_ex_ins),
    .id_ex_pc          (id_ex_pc),
    .id_ex_rd          (id_ex_rd),
    .id_ex_reg_write   (id_ex_reg_write),
    .id_ex_a           (id_ex_a),
    .id_ex_b           (id_ex_b),
    .id_ex_imm         (id_ex_imm),
    .ex_mem_valid      (ex_mem_valid),
    .ex_mem_ins        (ex_mem_ins),
    .ex_mem_rd         (ex_mem_rd),
    .ex_mem_rs         (ex_mem_rs),
    .ex_mem_reg_write  (ex_mem_reg_write),
    .ex_mem_result     (ex_mem_result),
    .ex_mem_addr       (ex_mem_addr),
    .ex_mem_store_data (ex_mem_store_data)
  );

  memory_stage memory_stage_inst (
    .clk               (clk),
    .arst_n            (arst_n),
    .ex_mem_valid      (ex_mem_valid),
    .ex_mem_ins        (ex_mem_ins),
    .ex_mem_rd         (ex_mem_rd),
    .ex_mem_rs         (ex_mem_rs),
    .ex_mem_reg_write  (ex_mem_reg_write),
    .ex_mem_result     (ex_mem_result),
    .ex_mem_addr       (ex_mem_addr),
    .ex_mem_store_data (ex_mem_store_data),
    .wb_en             (wb_en),
    .wb_reg            (wb_reg),
    .wb_data           (wb_data),
    .retire_valid      (retire_valid),
    .retire_reg        (retire_reg),
    .retire_data       (retire_data),
    .halted            (halted)
  );

  // the interlock only looks at decode, ID/EX and EX/MEM
  hazard_det hazard_det_inst (
    .dec_rs           (dec_rs),
    .dec_rt           (dec_rt),
    .id_ex_rd         (id_ex_rd),
    .id_ex_reg_write  (id_ex_reg_write),
    .ex_mem_rd        (ex_mem_rd),
    .ex_mem_rs        (ex_mem_rs),
    .ex_mem_reg_write (ex_mem_reg_write),
    .id_ex_ins        (id_ex_ins),
    .ex_mem_ins       (ex_mem_ins),
    .pc_source        (pc_source),
    .stall_decode     (stall_decode),
    .flush_fetch      (flush_fetch)
  );

endmodule

/* bench/isa_model.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// sequential reference of the instruction subset, one instruction per step with no pipeline
// so every register write is queued in program order
logic [word_w-1:0] model_rom [imem_depth];
logic [word_w-1:0] model_regs [2**reg_w];
logic [word_w-1:0] model_ram [dmem_depth];
logic [reg_w-1:0]  exp_reg_q [$];
logic [word_w-1:0] exp_data_q [$];
int                model_steps;
bit                model_ok;

// take the low bits of an instruction and copy the top field bit upward
function automatic logic [word_w-1:0] sign_extend(input logic [word_w-1:0] ins, input int bits);
  logic [word_w-1:0] mask;
  mask = (16'h1 << bits) - 16'h1;
  if (ins[bits-1]) begin
    return ins | ~mask;
  end
  return ins & mask;
endfunction

// every write updates the model state and becomes one expected retirement
function automatic void record_write(input logic [reg_w-1:0] r, input logic [word_w-1:0] v);
  model_regs[r] = v;
  exp_reg_q.push_back(r);
  exp_data_q.push_back(v);
endfunction

task automatic run_model();
  logic [word_w-1:0] pc;
  logic [word_w-1:0] ins;
  logic [word_w-1:0] addr;
  logic [op_w-1:0]   op;
  logic [reg_w-1:0]  rs;
  logic [reg_w-1:0]  rt;
  logic [reg_w-1:0]  rd;
  logic              done;
  $readmemh(rom_file, model_rom);
  for (int i = 0; i < 2**reg_w; i++) begin
    model_regs[i] = '0;
  end
  for (int i = 0; i < dmem_depth; i++) begin
    model_ram[i] = '0;
  end
  pc = '0;
  done = 1'b0;
  model_ok = 1'b1;
  model_steps = 0;
  while (!done) begin
    ins = model_rom[pc[imem_aw-1:0]];
    op = ins[op_lsb +: op_w];
    rs = ins[rs_lsb +: reg_w];
    rt = ins[rt_lsb +: reg_w];
    rd = ins[rd_lsb +: reg_w];
    // pc now points at the next word, which is also the link and branch base
    pc = pc + 16'd1;
    case (op)
      op_add:  record_write(rd, model_regs[rs] + model_regs[rt]);
      op_addi: record_write(rt, model_regs[rs] + sign_extend(ins, 5));
      op_lbi:  record_write(rs, sign_extend(ins, 8));
      op_ld: begin
        addr = model_regs[rs] + sign_extend(ins, 5);
        record_write(rt, model_ram[addr[dmem_aw-1:0]]);
      end
      op_st: begin
        addr = model_regs[rs] + sign_extend(ins, 5);
        model_ram[addr[dmem_aw-1:0]] = model_regs[rt];
      end
      op_stu: begin
        // the store uses the old base, then the base moves to the address
        addr = model_regs[rs] + sign_extend(ins, 5);
        model_ram[addr[dmem_aw-1:0]] = model_regs[rt];
        record_write(rs, addr);
      end
      op_beqz: begin
        if (model_regs[rs] == '0) begin
          pc = pc + sign_extend(ins, 8);
        end
      end
      op_j:    pc = pc + sign_extend(ins, 11);
      op_jal: begin
        record_write(link_reg, pc);
        pc = pc + sign_extend(ins, 11);
      end
      op_jr:   pc = model_regs[rs] + sign_extend(ins, 8);
      op_halt: done = 1'b1;
      default: begin
        model_ok = 1'b0;
        done = 1'b1;
      end
    endcase
    model_steps++;
    // a program that never halts would otherwise spin here forever
    if (model_steps >= 4 * imem_depth) begin
      model_ok = 1'b0;
      done = 1'b1;
    end
  end
endtask

`endif

/* bench/cpu_top_tb.sv */
`timescale 1ns/1ps

module cpu_top_tb;

  import cpu_pkg::*;

  logic              clk;
  logic              arst_n;
  logic              retire_valid;
  logic [reg_w-1:0]  retire_reg;
  logic [word_w-1:0] retire_data;
  logic              halted;

  // bookkeeping of the retirement monitor
  logic              halt_noticed = 1'b0;
  int                retired = 0;

  // stays zero until the model has counted its steps
  int                watchdog_cycles = 0;

  `include "isa_model.svh"

  cpu_top cpu_top_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .retire_valid (retire_valid),
    .retire_reg   (retire_reg),
    .retire_data  (retire_data),
    .halted       (halted)
  );

  always #50 clk = ~clk;

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    run_model();
    assert (model_ok)
      else stop_with_error("the model met an unknown opcode or never reached halt");
    watchdog_cycles = 4 * model_steps + 20;
    // reset spans three rising edges, the idle outputs are checked inside it
    repeat (2) @(posedge clk);
    @(negedge clk);
    assert (retire_valid == 1'b0)
      else stop_with_error($sformatf("Mismatch retire_valid in reset: got %h expected 0",
                                     retire_valid));
    assert (halted == 1'b0)
      else stop_with_error($sformatf("Mismatch halted in reset: got %h expected 0", halted));
    assert (cpu_top_inst.stall_decode == 1'b0)
      else stop_with_error($sformatf("Mismatch stall_decode in reset: got %h expected 0",
                                     cpu_top_inst.stall_decode));
    assert (cpu_top_inst.flush_fetch == 1'b0)
      else stop_with_error($sformatf("Mismatch flush_fetch in reset: got %h expected 0",
                                     cpu_top_inst.flush_fetch));
    @(posedge clk);
    #10 arst_n = 1'b1;
    // the program itself is the stimulus, so just wait for the core to stop
    while (!halted) begin
      @(negedge clk);
    end
    // a short quiet window in which the monitor watches for late retirements
    repeat (4) @(negedge clk);
    if (exp_reg_q.size() != 0) begin
      stop_with_error($sformatf("%0d expected register writes never retired", exp_reg_q.size()));
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

  // outputs are sampled on the falling edge, well away from the register updates
  always @(negedge clk) begin : retire_check
    logic [reg_w-1:0]  exp_reg;
    logic [word_w-1:0] exp_data;
    if (arst_n) begin
      if (halt_noticed) begin
        assert (halted) else stop_with_error("halted dropped after it had risen");
      end else if (halted) begin
        // halt leaves writeback last, so every expected write must be done by now
        assert (exp_reg_q.size() == 0)
          else stop_with_error($sformatf("halted rose with %0d register writes still expected",
                                         exp_reg_q.size()));
        halt_noticed = 1'b1;
      end
      if (retire_valid) begin
        assert (!halted) else stop_with_error("a register write retired after halted rose");
        assert (exp_reg_q.size() != 0)
          else stop_with_error("a register write retired that the program never makes");
        exp_reg = exp_reg_q.pop_front();
        exp_data = exp_data_q.pop_front();
        // a wrong-path write shows up here as a mismatch against the model
        assert (retire_reg == exp_reg)
          else stop_with_error($sformatf("Mismatch retire_reg at write %0d: got %h expected %h",
                                         retired, retire_reg, exp_reg));
        assert (retire_data == exp_data)
          else stop_with_error($sformatf("Mismatch retire_data at write %0d: got %h expected %h",
                                         retired, retire_data, exp_data));
        retired++;
      end
    end
  end

  // the limit comes from the model, so it scales with the program length
  initial begin : watchdog
    wait (watchdog_cycles > 0);
    wait (arst_n === 1'b1);
    repeat (watchdog_cycles) @(posedge clk);
    stop_with_error($sformatf("the core did not halt within %0d cycles", watchdog_cycles));
  end

endmodule

/* program.hex */
// one 16-bit instruction per line, word address 0 first
// opcode in bits 15..11, rs 10..8, rt 7..5, rd 4..2, immediates in the low bits
C105 // 00 lbi r1, 5
C2FD // 01 lbi r2, -3
D94C // 02 add r3, r1, r2
4387 // 03 addi r4, r3, 7
DC70 // 04 add r4, r4, r3
C510 // 05 lbi r5, 0x10
8582 // 06 st r4, [r5+2]
45C1 // 07 addi r6, r5, 1
8E21 // 08 ld r1, [r6+1]
D928 // 09 add r2, r1, r1
9D44 // 0a stu r2, [r5+4]
4560 // 0b addi r3, r5, 0
9D61 // 0c stu r3, [r5+1]
8DDF // 0d ld r6, [r5-1]
6001 // 0e beqz r0, +1 taken
C155 // 0f lbi r1, 0x55 wrong path
6401 // 10 beqz r4, +1 not taken
4121 // 11 addi r1, r1, 1
2001 // 12 j +1
C266 // 13 lbi r2, 0x66 wrong path
3001 // 14 jal +1
C377 // 15 lbi r3, 0x77 wrong path
2F03 // 16 jr r7, +3
C444 // 17 lbi r4, 0x44 wrong path
DF24 // 18 add r1, r7, r1
0000 // 19 halt

/* cpu_top.f */
+incdir+bench
verilog/cpu_pkg.sv
verilog/hazard_det.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/cpu_top.sv
bench/cpu_top_tb.sv

/* Makefile */
# Verilator build and run of the cpu_top testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build cpu_top_tb with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	  --top-module cpu_top_tb -f cpu_top.f -o cpu_top_tb
	./obj_dir/cpu_top_tb

clean:
	rm -rf obj_dir
